//--- common/pktgen_pkg.sv
////////////////////////////////////////
// Packet generator shared widths, register map
// and the flow, beat, stats and control types
////////////////////////////////////////

package pktgen_pkg;

    ////////////////////////////////////////
    // Widths

    localparam int beat_bytes     = 8;
    localparam int flow_idx_w     = 4;
    localparam int flow_def_words = 5;

    ////////////////////////////////////////
    // Register map

    localparam logic [7:0] reg_params      = 8'd0;
    localparam logic [7:0] reg_status      = 8'd1;
    localparam logic [7:0] reg_tx_con      = 8'd2;
    localparam logic [7:0] reg_flow_con    = 8'd3;
    localparam logic [7:0] reg_pkt_cnt     = 8'd4;
    localparam logic [7:0] reg_byte_cnt_lo = 8'd5;
    localparam logic [7:0] reg_byte_cnt_hi = 8'd6;
    // First of flow_def_words data registers, MSBs first
    localparam logic [7:0] reg_flow_data   = 8'd8;

    ////////////////////////////////////////
    // Flow definition, 134 bits

    typedef struct packed {
        logic [47:0] mac_da;
        logic [47:0] mac_sa;
        logic [15:0] ether_type;
        logic [13:0] pkt_len;
        logic [7:0]  payload_value;
    } flow_def_t;

    ////////////////////////////////////////
    // Control words

    typedef struct packed {
        logic [27:0] tx_count;
        logic [1:0]  reserved;
        logic        finite;
        logic        enable;
    } tx_con_t;

    // Commit writes the staged words, otherwise flow_id is the last active flow
    typedef struct packed {
        logic [15:0] flow_id;
        logic [14:0] reserved;
        logic        commit;
    } flow_con_t;

    // Decoded by register address
    typedef union packed {
        tx_con_t   tx;
        flow_con_t flow;
    } ctrl_word_u;

    ////////////////////////////////////////
    // Stream beat and totals

    // Byte 0 sits in the top byte, keep bit 7 covers it
    typedef struct packed {
        logic [8*beat_bytes-1:0] data;
        logic [beat_bytes-1:0]   keep;
        logic                    last;
        logic [flow_idx_w-1:0]   flow;
    } beat_t;

    typedef struct packed {
        logic [31:0] pkt_cnt;
        logic [63:0] byte_cnt;
    } tx_stats_t;

endpackage

//--- verilog/beat_fifo.sv
////////////////////////////////////////
// Synchronous beat FIFO
////////////////////////////////////////

`timescale 1ns/100ps

module beat_fifo
    import pktgen_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic  avmm_clk_ifc,
    input  logic  core_sresetn,
    input  logic  push,
    input  beat_t push_beat,
    output logic  full,
    input  logic  pop,
    output beat_t pop_beat,
    output logic  empty
);

    localparam int aw = $clog2(DEPTH);

    beat_t       mem [DEPTH];
    logic [aw:0] wr_ptr;
    logic [aw:0] rd_ptr;

    // Top pointer bit tells a full buffer from an empty one
    assign empty    = wr_ptr == rd_ptr;
    assign full     = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
    assign pop_beat = mem[rd_ptr[aw-1:0]];

    always_ff @(posedge avmm_clk_ifc) begin
        if (push && !full) begin
            mem[wr_ptr[aw-1:0]] <= push_beat;
        end
    end

    always_ff @(posedge avmm_clk_ifc) begin
        if (!core_sresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- pktgen/pktgen_regs.sv
////////////////////////////////////////
// Register block with flow table and read mux
////////////////////////////////////////

`timescale 1ns/100ps

module pktgen_regs
    import pktgen_pkg::*;
#(
    parameter int NUM_FLOWS = 10
) (
    input  logic                  avmm_clk_ifc,
    input  logic                  core_sresetn,
    input  logic                  wr_en,
    input  logic                  rd_en,
    input  logic [7:0]            addr,
    input  logic [31:0]           wr_data,
    output logic [31:0]           rd_data,
    output logic                  rd_valid,
    input  logic [flow_idx_w-1:0] flow_sel,
    output flow_def_t             flow_def,
    output logic [flow_idx_w-1:0] last_flow,
    output tx_con_t               tx_ctrl,
    input  logic                  running,
    input  tx_stats_t             stats
);

    localparam int word_sel_w = $clog2(flow_def_words);

    logic [31:0]                  data_words [flow_def_words];
    logic [32*flow_def_words-1:0] staged_vec;
    flow_def_t                    staged_def;
    flow_def_t                    flow_table [NUM_FLOWS];
    ctrl_word_u                   wr_word;
    logic [7:0]                   data_idx;
    logic                         data_hit;
    logic                         flow_in_range;
    logic [31:0]                  rd_mux;

    assign wr_word  = wr_data;
    assign data_idx = addr - reg_flow_data;
    assign data_hit = (addr >= reg_flow_data) && (data_idx < 8'(flow_def_words));

    assign flow_in_range = wr_word.flow.flow_id < 16'(NUM_FLOWS);

    // Builder lookup, answered in the same cycle
    assign flow_def = (flow_sel < NUM_FLOWS) ? flow_table[flow_sel] : '0;

    // Word 0 carries the top bits of the definition
    always_comb begin
        for (int i = 0; i < flow_def_words; i++) begin
            staged_vec[32*(flow_def_words-1-i) +: 32] = data_words[i];
        end
        staged_def = flow_def_t'(staged_vec[32*flow_def_words-1 -: $bits(flow_def_t)]);
    end

    ////////////////////////////////////////
    // Writes

    always_ff @(posedge avmm_clk_ifc) begin
        if (!core_sresetn) begin
            tx_ctrl   <= '0;
            last_flow <= '0;
            for (int i = 0; i < flow_def_words; i++) begin
                data_words[i] <= '0;
            end
            for (int f = 0; f < NUM_FLOWS; f++) begin
                flow_table[f] <= '0;
            end
        end else if (wr_en) begin
            if (data_hit) begin
                data_words[data_idx[word_sel_w-1:0]] <= wr_data;
            end
            if (addr == reg_tx_con) begin
                tx_ctrl <= wr_word.tx;
            end
            if (addr == reg_flow_con) begin
                if (wr_word.flow.commit) begin
                    if (flow_in_range) begin
                        flow_table[wr_word.flow.flow_id[flow_idx_w-1:0]] <= staged_def;
                    end
                end else if (flow_in_range) begin
                    last_flow <= wr_word.flow.flow_id[flow_idx_w-1:0];
                end else begin
                    last_flow <= flow_idx_w'(NUM_FLOWS - 1);
                end
            end
        end
    end

    ////////////////////////////////////////
    // Reads

    always_comb begin
        rd_mux = '0;
        case (addr)
            reg_params:      rd_mux = 32'(NUM_FLOWS);
            reg_status:      rd_mux[0] = running;
            reg_tx_con:      rd_mux = tx_ctrl;
            reg_flow_con:    rd_mux[31:16] = 16'(last_flow);
            reg_pkt_cnt:     rd_mux = stats.pkt_cnt;
            reg_byte_cnt_lo: rd_mux = stats.byte_cnt[31:0];
            reg_byte_cnt_hi: rd_mux = stats.byte_cnt[63:32];
            default: begin
                if (data_hit) begin
                    rd_mux = data_words[data_idx[word_sel_w-1:0]];
                end
            end
        endcase
    end

    always_ff @(posedge avmm_clk_ifc) begin
        if (!core_sresetn) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
        if (rd_en) begin
            rd_data <= rd_mux;
        end
    end

endmodule

//--- pktgen/pktgen_frame_builder.sv
////////////////////////////////////////
// Frame builder, walks the flows round-robin
// and turns each definition into beats
////////////////////////////////////////

`timescale 1ns/100ps

module pktgen_frame_builder
    import pktgen_pkg::*;
(
    input  logic                  avmm_clk_ifc,
    input  logic                  core_sresetn,
    input  tx_con_t               tx_ctrl,
    input  logic [flow_idx_w-1:0] last_flow,
    output logic [flow_idx_w-1:0] flow_sel,
    input  flow_def_t             flow_def,
    output logic                  running,
    output logic                  push,
    output beat_t                 push_beat,
    input  logic                  full
);

    localparam int hdr_bytes = 14;

    logic                   in_frame;
    logic [13:0]            byte_off;
    logic [flow_idx_w-1:0]  cur_flow;
    logic [27:0]            frame_cnt;
    logic                   enable_q;
    logic                   restart;
    logic                   enable_rise;
    logic                   restart_now;
    logic                   can_start;
    logic                   frame_start;
    logic [27:0]            cnt_eff;
    logic [27:0]            cnt_base;
    logic [flow_idx_w-1:0]  start_flow;
    logic [flow_idx_w-1:0]  next_flow;
    logic [8*hdr_bytes-1:0] hdr;
    logic [14:0]            end_off;

    ////////////////////////////////////////
    // Frame start and stop

    // A restart is held until the next frame actually begins
    assign enable_rise = tx_ctrl.enable & ~enable_q;
    assign restart_now = restart | enable_rise;
    assign cnt_eff     = restart_now ? '0 : frame_cnt;
    assign start_flow  = restart_now ? '0 : cur_flow;

    assign can_start = tx_ctrl.enable & (~tx_ctrl.finite | (cnt_eff < tx_ctrl.tx_count));

    assign flow_sel    = in_frame ? cur_flow : start_flow;
    assign running     = in_frame | can_start;
    assign push        = ~full & (in_frame | can_start);
    assign frame_start = push & ~in_frame;
    assign cnt_base    = in_frame ? frame_cnt : cnt_eff;
    assign next_flow   = (flow_sel >= last_flow) ? '0 : flow_sel + 1'b1;

    ////////////////////////////////////////
    // Beat contents

    assign hdr     = {flow_def.mac_da, flow_def.mac_sa, flow_def.ether_type};
    assign end_off = {1'b0, byte_off} + 15'(beat_bytes);

    always_comb begin : beat_build
        logic [14:0] pos;

        push_beat = '0;
        for (int i = 0; i < beat_bytes; i++) begin
            pos = {1'b0, byte_off} + 15'(i);
            if (pos < 15'(hdr_bytes)) begin
                push_beat.data[8*(beat_bytes-1-i) +: 8] = hdr[8*(hdr_bytes-1-int'(pos)) +: 8];
            end else begin
                push_beat.data[8*(beat_bytes-1-i) +: 8] = flow_def.payload_value;
            end
            push_beat.keep[beat_bytes-1-i] = pos < {1'b0, flow_def.pkt_len};
        end
        push_beat.last = end_off >= {1'b0, flow_def.pkt_len};
        push_beat.flow = flow_sel;
    end

    ////////////////////////////////////////
    // Flow, offset and frame count

    always_ff @(posedge avmm_clk_ifc) begin
        if (!core_sresetn) begin
            in_frame  <= 1'b0;
            byte_off  <= '0;
            cur_flow  <= '0;
            frame_cnt <= '0;
            enable_q  <= 1'b0;
            restart   <= 1'b0;
        end else begin
            enable_q <= tx_ctrl.enable;
            if (frame_start) begin
                restart <= 1'b0;
            end else if (enable_rise) begin
                restart <= 1'b1;
            end
            if (push) begin
                if (push_beat.last) begin
                    in_frame  <= 1'b0;
                    byte_off  <= '0;
                    cur_flow  <= next_flow;
                    frame_cnt <= cnt_base + 28'd1;
                end else begin
                    in_frame <= 1'b1;
                    byte_off <= end_off[13:0];
                    cur_flow <= flow_sel;
                    if (frame_start) begin
                        frame_cnt <= cnt_eff;
                    end
                end
            end
        end
    end

endmodule

//--- pktgen/pktgen_stream_tx.sv
////////////////////////////////////////
// Stream sender with packet and byte totals
////////////////////////////////////////

`timescale 1ns/100ps

module pktgen_stream_tx
    import pktgen_pkg::*;
(
    input  logic      avmm_clk_ifc,
    input  logic      core_sresetn,
    output logic      pop,
    input  beat_t     pop_beat,
    input  logic      empty,
    output beat_t     out_beat,
    output logic      out_valid,
    input  logic      out_ready,
    output tx_stats_t stats
);

    localparam int cnt_w = $clog2(beat_bytes) + 1;

    logic take;

    function automatic logic [cnt_w-1:0] keep_bytes(input logic [beat_bytes-1:0] keep);
        logic [cnt_w-1:0] count;

        count = '0;
        for (int i = 0; i < beat_bytes; i++) begin
            count = count + cnt_w'(keep[i]);
        end
        return count;
    endfunction

    // Refill when the register is empty or drains this cycle
    assign take = out_valid & out_ready;
    assign pop  = ~empty & (~out_valid | out_ready);

    always_ff @(posedge avmm_clk_ifc) begin
        if (pop) begin
            out_beat <= pop_beat;
        end
    end

    always_ff @(posedge avmm_clk_ifc) begin
        if (!core_sresetn) begin
            out_valid <= 1'b0;
        end else if (pop) begin
            out_valid <= 1'b1;
        end else if (take) begin
            out_valid <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Totals

    always_ff @(posedge avmm_clk_ifc) begin
        if (!core_sresetn) begin
            stats <= '0;
        end else if (take) begin
            stats.byte_cnt <= stats.byte_cnt + 64'(keep_bytes(out_beat.keep));
            if (out_beat.last) begin
                stats.pkt_cnt <= stats.pkt_cnt + 32'd1;
            end
        end
    end

endmodule

//--- pktgen/pktgen_top.sv
////////////////////////////////////////
// Packet generator top level
////////////////////////////////////////

`timescale 1ns/100ps

module pktgen_top
    import pktgen_pkg::*;
#(
    parameter int NUM_FLOWS  = 10,
    parameter int FIFO_DEPTH = 16
) (
    input  logic        avmm_clk_ifc,
    input  logic        core_sresetn,
    input  logic        wr_en,
    input  logic        rd_en,
    input  logic [7:0]  addr,
    input  logic [31:0] wr_data,
    output logic [31:0] rd_data,
    output logic        rd_valid,
    output beat_t       out_beat,
    output logic        out_valid,
    input  logic        out_ready
);

    logic [flow_idx_w-1:0] flow_sel;
    flow_def_t             flow_def;
    logic [flow_idx_w-1:0] last_flow;
    tx_con_t               tx_ctrl;
    logic                  running;
    tx_stats_t             stats;
    logic                  push;
    beat_t                 push_beat;
    logic                  full;
    logic                  pop;
    beat_t                 pop_beat;
    logic                  empty;

    pktgen_regs #(
        .NUM_FLOWS ( NUM_FLOWS )
    ) regs0 (
        .avmm_clk_ifc ( avmm_clk_ifc ),
        .core_sresetn ( core_sresetn ),
        .wr_en        ( wr_en        ),
        .rd_en        ( rd_en        ),
        .addr         ( addr         ),
        .wr_data      ( wr_data      ),
        .rd_data      ( rd_data      ),
        .rd_valid     ( rd_valid     ),
        .flow_sel     ( flow_sel     ),
        .flow_def     ( flow_def     ),
        .last_flow    ( last_flow    ),
        .tx_ctrl      ( tx_ctrl      ),
        .running      ( running      ),
        .stats        ( stats        )
    );

    pktgen_frame_builder builder0 (
        .avmm_clk_ifc ( avmm_clk_ifc ),
        .core_sresetn ( core_sresetn ),
        .tx_ctrl      ( tx_ctrl      ),
        .last_flow    ( last_flow    ),
        .flow_sel     ( flow_sel     ),
        .flow_def     ( flow_def     ),
        .running      ( running      ),
        .push         ( push         ),
        .push_beat    ( push_beat    ),
        .full         ( full         )
    );

    beat_fifo #(
        .DEPTH ( FIFO_DEPTH )
    ) fifo0 (
        .avmm_clk_ifc ( avmm_clk_ifc ),
        .core_sresetn ( core_sresetn ),
        .push         ( push         ),
        .push_beat    ( push_beat    ),
        .full         ( full         ),
        .pop          ( pop          ),
        .pop_beat     ( pop_beat     ),
        .empty        ( empty        )
    );

    pktgen_stream_tx tx0 (
        .avmm_clk_ifc ( avmm_clk_ifc ),
        .core_sresetn ( core_sresetn ),
        .pop          ( pop          ),
        .pop_beat     ( pop_beat     ),
        .empty        ( empty        ),
        .out_beat     ( out_beat     ),
        .out_valid    ( out_valid    ),
        .out_ready    ( out_ready    ),
        .stats        ( stats        )
    );

endmodule

//--- verif/pktgen_model.svh
////////////////////////////////////////
// Expected beat model and xorshift generator
////////////////////////////////////////

`ifndef pktgen_model_svh
`define pktgen_model_svh

flow_def_t             model_flows [16];
logic [flow_idx_w-1:0] model_last;
logic [flow_idx_w-1:0] model_next;
beat_t                 exp_q [$];
tx_stats_t             exp_stats;

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;

    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Queue every beat of the next round-robin frame
task automatic expand_next_frame();
    flow_def_t    d;
    logic [111:0] hdr;
    beat_t        b;
    int           nbeats;
    int           pos;

    d = model_flows[model_next];
    hdr = {d.mac_da, d.mac_sa, d.ether_type};
    nbeats = (int'(d.pkt_len) + beat_bytes - 1) / beat_bytes;
    for (int k = 0; k < nbeats; k++) begin
        b = '0;
        for (int j = 0; j < beat_bytes; j++) begin
            pos = beat_bytes * k + j;
            if (pos < 14) begin
                b.data[8*(beat_bytes-1-j) +: 8] = hdr[8*(13-pos) +: 8];
            end else begin
                b.data[8*(beat_bytes-1-j) +: 8] = d.payload_value;
            end
            b.keep[beat_bytes-1-j] = (pos < int'(d.pkt_len));
        end
        b.last = (k == nbeats - 1);
        b.flow = model_next;
        exp_q.push_back(b);
    end
    exp_stats.pkt_cnt = exp_stats.pkt_cnt + 32'd1;
    exp_stats.byte_cnt = exp_stats.byte_cnt + 64'(d.pkt_len);
    model_next = (model_next == model_last) ? '0 : model_next + 1'b1;
endtask

`endif

//--- verif/tb_pktgen.sv
////////////////////////////////////////
// Packet generator testbench with random flows,
// random back-pressure and a beat model
////////////////////////////////////////

`timescale 1ns/100ps

module tb_pktgen
    import pktgen_pkg::*;
();

    localparam int num_flows  = 10;
    localparam int fifo_depth = 16;
    localparam int wait_limit = 20000;

    logic        avmm_clk_ifc;
    logic        core_sresetn;
    logic        wr_en;
    logic        rd_en;
    logic [7:0]  addr;
    logic [31:0] wr_data;
    logic [31:0] rd_data;
    logic        rd_valid;
    beat_t       out_beat;
    logic        out_valid;
    logic        out_ready;

    logic [31:0] rng;
    logic [31:0] ready_rng;
    logic        random_ready;
    logic        open_ended;
    int          rx_frames;
    logic        stalled;
    beat_t       held_beat;
    beat_t       exp_beat;

    `include "pktgen_model.svh"

    pktgen_top #(
        .NUM_FLOWS  ( num_flows  ),
        .FIFO_DEPTH ( fifo_depth )
    ) dut0 (
        .avmm_clk_ifc ( avmm_clk_ifc ),
        .core_sresetn ( core_sresetn ),
        .wr_en        ( wr_en        ),
        .rd_en        ( rd_en        ),
        .addr         ( addr         ),
        .wr_data      ( wr_data      ),
        .rd_data      ( rd_data      ),
        .rd_valid     ( rd_valid     ),
        .out_beat     ( out_beat     ),
        .out_valid    ( out_valid    ),
        .out_ready    ( out_ready    )
    );

    initial begin
        avmm_clk_ifc = 1'b0;
        forever #4 avmm_clk_ifc = ~avmm_clk_ifc;
    end

    ////////////////////////////////////////
    // Checks

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s read %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_beat(input beat_t got, input beat_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s data %h keep %b last %b flow %0d", $time, what,
                got.data, got.keep, got.last, got.flow);
            $display("    expected data %h keep %b last %b flow %0d",
                exp.data, exp.keep, exp.last, exp.flow);
            stop_run();
        end
    endtask

    task automatic check_stats(input tx_stats_t got, input tx_stats_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s packets %0d bytes %0d, expected packets %0d bytes %0d",
                $time, what, got.pkt_cnt, got.byte_cnt, exp.pkt_cnt, exp.byte_cnt);
            stop_run();
        end
    endtask

    ////////////////////////////////////////
    // Register access

    task automatic next_cycle();
        @(posedge avmm_clk_ifc);
        #1;
    endtask

    task automatic reg_write(input logic [7:0] a, input logic [31:0] d);
        wr_en = 1'b1;
        addr = a;
        wr_data = d;
        next_cycle();
        wr_en = 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] a, output logic [31:0] d);
        rd_en = 1'b1;
        addr = a;
        next_cycle();
        rd_en = 1'b0;
        if (rd_valid !== 1'b1) begin
            $display("rd_valid did not rise one cycle after the read strobe");
            stop_run();
        end
        d = rd_data;
        next_cycle();
        if (rd_valid !== 1'b0) begin
            $display("rd_valid stayed high longer than one cycle");
            stop_run();
        end
    endtask

    task automatic check_reg(input logic [7:0] a, input logic [31:0] exp, input string what);
        logic [31:0] w;

        reg_read(a, w);
        check_word(w, exp, what);
    endtask

    task automatic check_counters(input string what);
        tx_stats_t   got;
        logic [31:0] w;

        reg_read(reg_pkt_cnt, w);
        got.pkt_cnt = w;
        reg_read(reg_byte_cnt_lo, w);
        got.byte_cnt[31:0] = w;
        reg_read(reg_byte_cnt_hi, w);
        got.byte_cnt[63:32] = w;
        check_stats(got, exp_stats, what);
    endtask

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Lengths 14 to 200 bytes
    function automatic flow_def_t random_flow();
        flow_def_t   d;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] r4;

        r0 = rand32();
        r1 = rand32();
        r2 = rand32();
        r3 = rand32();
        r4 = rand32();
        d.mac_da = {r0[15:0], r1};
        d.mac_sa = {r0[31:16], r2};
        d.ether_type = r3[15:0];
        d.payload_value = r3[23:16];
        d.pkt_len = 14'(14 + r4 % 187);
        return d;
    endfunction

    task automatic write_flow(input int id, input flow_def_t def);
        logic [32*flow_def_words-1:0] vec;

        vec = '0;
        vec[32*flow_def_words-1 -: $bits(flow_def_t)] = def;
        for (int i = 0; i < flow_def_words; i++) begin
            reg_write(reg_flow_data + 8'(i), vec[32*(flow_def_words-1-i) +: 32]);
        end
        reg_write(reg_flow_con, {16'(id), 15'd0, 1'b1});
        model_flows[id] = def;
    endtask

    task automatic set_last_flow(input int id);
        reg_write(reg_flow_con, {16'(id), 15'd0, 1'b0});
        model_last = flow_idx_w'(id);
    endtask

    // Enable rises, so the builder restarts at flow 0
    // Finite runs queue every expected frame up front
    task automatic start_run(input logic finite, input int count);
        reg_write(reg_tx_con, 32'd0);
        model_next = '0;
        open_ended = !finite;
        if (finite) begin
            for (int n = 0; n < count; n++) begin
                expand_next_frame();
            end
        end
        reg_write(reg_tx_con, {28'(count), 2'b00, finite, 1'b1});
    endtask

    task automatic wait_frames(input int n, input string what);
        int start;
        int cycles;

        start = rx_frames;
        cycles = 0;
        while (rx_frames - start < n) begin
            if (cycles >= wait_limit) begin
                $display("Timed out waiting for %s", what);
                stop_run();
            end
            cycles++;
            next_cycle();
        end
    endtask

    task automatic wait_drain(input string what);
        logic [31:0] w;
        int          cycles;

        cycles = 0;
        reg_read(reg_status, w);
        while (w[0] !== 1'b0 || out_valid !== 1'b0 || exp_q.size() != 0) begin
            if (cycles >= wait_limit) begin
                $display("Timed out waiting for %s to end on a frame boundary", what);
                stop_run();
            end
            cycles++;
            reg_read(reg_status, w);
        end
    endtask

    ////////////////////////////////////////
    // Output monitor and ready driver

    always @(posedge avmm_clk_ifc) begin
        if (core_sresetn === 1'b1) begin
            if (stalled) begin
                check_beat(out_beat, held_beat, "beat held during stall");
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    if (!open_ended) begin
                        $display("Unexpected beat at %0t after the last expected frame", $time);
                        stop_run();
                    end else begin
                        expand_next_frame();
                    end
                end
                exp_beat = exp_q.pop_front();
                check_beat(out_beat, exp_beat, "output beat");
                if (out_beat.last) begin
                    rx_frames++;
                end
            end
            stalled = out_valid && !out_ready;
            held_beat = out_beat;
        end
    end

    always @(posedge avmm_clk_ifc) begin : ready_drive
        logic use_random;

        use_random = random_ready;
        #1;
        if (use_random) begin
            ready_rng = xorshift(ready_rng);
            out_ready = (ready_rng[4:3] != 2'b00);
        end else begin
            out_ready = 1'b1;
        end
    end

    ////////////////////////////////////////
    // Test sequence

    initial begin
        int stop_wait;

        core_sresetn = 1'b0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        addr = '0;
        wr_data = '0;
        out_ready = 1'b1;
        random_ready = 1'b0;
        open_ended = 1'b0;
        rng = 32'd46;
        ready_rng = 32'd46;
        rx_frames = 0;
        stalled = 1'b0;
        model_last = '0;
        model_next = '0;
        exp_stats = '0;
        for (int f = 0; f < 16; f++) begin
            model_flows[f] = '0;
        end
        repeat (8) next_cycle();
        core_sresetn = 1'b1;
        next_cycle();

        check_reg(reg_params, 32'(num_flows), "parameters register");
        check_reg(reg_status, 32'd0, "status after reset");

        for (int f = 0; f < 7; f++) begin
            write_flow(f, random_flow());
        end
        set_last_flow(5);

        // Finite run at full rate
        start_run(1'b1, 24);
        wait_frames(24, "the first finite run");
        wait_drain("the first finite run");
        check_reg(reg_status, 32'd0, "status after the first finite run");

        // Same traffic under random back-pressure
        random_ready = 1'b1;
        start_run(1'b1, 30);
        wait_frames(30, "the finite run with back-pressure");
        wait_drain("the finite run with back-pressure");
        check_reg(reg_status, 32'd0, "status after the second finite run");
        check_counters("totals after the finite runs");

        // Continuous mode, stopped at a random point
        start_run(1'b0, 0);
        stop_wait = 100 + int'(rand32() % 32'd400);
        repeat (stop_wait) next_cycle();
        reg_write(reg_tx_con, 32'd0);
        wait_drain("the continuous run");
        check_counters("totals after the continuous run");

        // Flow 7 stays out of traffic until last_flow covers it
        write_flow(7, random_flow());
        start_run(1'b1, 12);
        wait_frames(12, "the run with flow 7 inactive");
        wait_drain("the run with flow 7 inactive");
        set_last_flow(7);
        start_run(1'b1, 16);
        wait_frames(16, "the run with flow 7 active");
        wait_drain("the run with flow 7 active");
        check_reg(reg_status, 32'd0, "status after the last run");
        check_counters("final totals");

        $display("All tests passed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verif
common/pktgen_pkg.sv
verilog/beat_fifo.sv
pktgen/pktgen_regs.sv
pktgen/pktgen_frame_builder.sv
pktgen/pktgen_stream_tx.sv
pktgen/pktgen_top.sv
verif/tb_pktgen.sv

//--- run.sh
#!/bin/sh
# Build and run the packet generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_pktgen -f filelist.f -o sim_pktgen
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/sim_pktgen
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation reported a failure"
    exit $status
fi

echo "Simulation finished without errors"
exit 0
